// ==== bench/lsu_tb.sv ====
/*
 * load/store unit testbench
 * directed accesses against a 16-word memory model with random grant delays
 */

`timescale 1ns/1ns
`default_nettype none

`include "lsu_consts.svh"

module lsu_tb;
  import lsu_core_pkg::*;
  import lsu_bus_pkg::*;

  localparam int         MAX_CYCLES = 2000;   // about 50 accesses of at most 8 cycles plus margin
  localparam logic [3:0] ERR_WORD   = 4'd13;  // word at byte address 0x34 answers with err

  logic                   clk_i;
  logic                   rst_ni;
  logic                   req_i;
  core_req_t              core_req_i;
  logic                   req_done_o;
  logic                   resp_valid_o;
  logic                   load_err_o;
  logic                   store_err_o;
  logic                   busy_o;
  logic [`LSU_DATA_W-1:0] rdata_o;
  logic [`LSU_ADDR_W-1:0] addr_last_o;
  logic                   data_req_o;
  bus_req_t               bus_req_o;
  logic                   gnt_i;
  logic                   rvalid_i;
  bus_rsp_t               bus_rsp_i;

  logic [31:0] mem     [16];  // memory model
  logic [31:0] ref_mem [16];  // what the tests expect memory to hold
  logic [31:0] lcg_state;
  int          next_wait;     // grant delay of the next access set before req_i rises
  int          gnt_left;
  int          n_checks;
  int          n_errors;
  int          cycles;

  lsu_top dut0 (.*);  // port names match one to one

  always #20 clk_i = ~clk_i;

  // run limit so a stuck handshake ends the run
  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("Done: errors found");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////
  // helpers
  function automatic int lcg_wait();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return int'(lcg_state[25:24]);  // 0 to 3 cycles
  endfunction

  function automatic logic [31:0] fill_word(input int i);
    return 32'h9e37_79b9 * 32'(i + 1);  // whole index mixed in
  endfunction

  function automatic int size_bytes(input lsu_size_e size);
    case (size)
      SIZE_WORD: return 4;
      SIZE_HALF: return 2;
      default:   return 1;  // code 3 is a byte as well
    endcase
  endfunction

  // addressed bytes at bit 0 with upper bytes zero or copies of the top bit
  function automatic logic [31:0] expect_load(input logic [31:0] word, input int offs,
                                              input int nb, input logic sx);
    logic [31:0] v;
    logic        fill;
    v    = word >> (8 * offs);
    fill = sx & v[8*nb-1];
    for (int b = nb; b < 4; b++)
      v[8*b +: 8] = {8{fill}};
    return v;
  endfunction

  task automatic check_val(input string name, input logic [31:0] exp_v,
                           input logic [31:0] act_v);
    n_checks++;
    assert (act_v === exp_v) else begin
      $display("ERR %0t %s exp %h got %h", $time, name, exp_v, act_v);
      n_errors++;
    end
  endtask

  //////////////////////////////////////////////////////////////
  // memory model grants after next_wait cycles and answers one cycle later
  initial begin
    logic [31:0] merged;
    logic [3:0]  widx;
    gnt_i     <= 1'b0;
    rvalid_i  <= 1'b0;
    bus_rsp_i <= '0;
    gnt_left  <= 0;
    for (int i = 0; i < 16; i++)
      mem[i] = fill_word(i);
    forever begin
      @(posedge clk_i);
      rvalid_i  <= 1'b0;
      bus_rsp_i <= '0;  // err only travels with rvalid
      if (!rst_ni) begin
        gnt_i <= 1'b0;
      end else if (data_req_o && gnt_i) begin
        widx      = bus_req_o.addr[5:2];
        rvalid_i  <= 1'b1;
        bus_rsp_i <= '{rdata: mem[widx], err: (widx == ERR_WORD)};
        gnt_i     <= 1'b0;
        merged    = mem[widx];
        for (int i = 0; i < 4; i++) begin
          if (bus_req_o.be[i])
            merged[8*i +: 8] = bus_req_o.wdata[8*i +: 8];  // lane by lane
        end
        if (bus_req_o.we)
          mem[widx] = merged;
      end else if (data_req_o) begin
        if (gnt_left <= 1)
          gnt_i <= 1'b1;
        else
          gnt_left <= gnt_left - 1;
      end else begin
        gnt_i    <= (next_wait == 0);  // zero delay grants in the first request cycle
        gnt_left <= next_wait;
      end
    end
  end

  //////////////////////////////////////////////////////////////
  // one core access with checks on request, grant wait, done and response
  task automatic run_access(input logic we, input lsu_size_e size, input logic sx,
                            input logic [31:0] addr, input logic [31:0] wdata,
                            input int wait_cyc);
    bus_req_t    req0;
    logic [3:0]  exp_be;
    logic [31:0] exp_wd;
    logic [31:0] mask;
    logic [31:0] exp_rd;
    logic        is_err;
    int          offs;
    int          nb;
    int          k;
    offs   = int'(addr[1:0]);
    nb     = size_bytes(size);
    is_err = (addr[5:2] == ERR_WORD);
    exp_rd = expect_load(ref_mem[addr[5:2]], offs, nb, sx);
    exp_be = '0;
    exp_wd = '0;
    for (int i = 0; i < 4; i++) begin
      if (i >= offs && i < offs + nb) begin
        exp_be[i]        = 1'b1;
        exp_wd[8*i +: 8] = wdata[8*(i-offs) +: 8];  // data byte 0 lands in lane offs
      end
    end
    mask = {{8{exp_be[3]}}, {8{exp_be[2]}}, {8{exp_be[1]}}, {8{exp_be[0]}}};
    if (we)
      ref_mem[addr[5:2]] = (ref_mem[addr[5:2]] & ~mask) | exp_wd;

    next_wait = wait_cyc;
    @(posedge clk_i);
    req_i      <= 1'b1;
    core_req_i <= '{we: we, size: size, sign_ext: sx, wdata: wdata, addr: addr};
    @(negedge clk_i);
    req0 = bus_req_o;
    check_val("bus_req_o.addr", {addr[31:2], 2'b00}, req0.addr);
    check_val("bus_req_o.we", 32'(we), 32'(req0.we));
    if (we) begin
      check_val("bus_req_o.be", 32'(exp_be), 32'(req0.be));
      check_val("bus_req_o.wdata", exp_wd, req0.wdata & mask);
    end
    // request held until the grant and done only in the grant cycle
    k = 0;
    forever begin
      check_val("data_req_o", 32'd1, 32'(data_req_o));
      check_val("busy_o", 32'(k > 0), 32'(busy_o));
      check_val("req_done_o", 32'(k == wait_cyc), 32'(req_done_o));
      n_checks++;
      assert (bus_req_o === req0) else begin
        $display("ERR %0t bus_req_o exp %h got %h", $time, req0, bus_req_o);
        n_errors++;
      end
      if (req_done_o || k >= wait_cyc)
        break;
      k++;
      @(negedge clk_i);
    end
    @(posedge clk_i);
    req_i <= 1'b0;
    @(negedge clk_i);
    check_val("addr_last_o", addr, addr_last_o);  // full byte address
    while (!resp_valid_o) begin
      check_val("resp_valid_o", 32'(rvalid_i), 32'(resp_valid_o));
      check_val("load_err_o", 32'd0, 32'(load_err_o));
      check_val("store_err_o", 32'd0, 32'(store_err_o));
      @(negedge clk_i);
    end
    check_val("load_err_o", 32'(is_err && !we), 32'(load_err_o));
    check_val("store_err_o", 32'(is_err && we), 32'(store_err_o));
    if (!we)
      check_val("rdata_o", exp_rd, rdata_o);
  endtask

  //////////////////////////////////////////////////////////////
  // directed tests
  task automatic reset_outputs();
    check_val("data_req_o", 32'd0, 32'(data_req_o));
    check_val("req_done_o", 32'd0, 32'(req_done_o));
    check_val("busy_o", 32'd0, 32'(busy_o));
    check_val("resp_valid_o", 32'd0, 32'(resp_valid_o));
    check_val("load_err_o", 32'd0, 32'(load_err_o));
    check_val("store_err_o", 32'd0, 32'(store_err_o));
    check_val("addr_last_o", 32'd0, addr_last_o);
  endtask

  task automatic word_roundtrip();
    run_access(1'b1, SIZE_WORD, 1'b0, 32'h08, 32'hdead_beef, lcg_wait());
    run_access(1'b0, SIZE_WORD, 1'b0, 32'h08, 32'h0, lcg_wait());
  endtask

  // each partial store followed by a word load of the merged result
  task automatic partial_stores();
    for (int o = 0; o < 4; o++) begin
      run_access(1'b1, SIZE_BYTE, 1'b0, 32'h10 + 32'(o), 32'h1234_56a0 | 32'(o), lcg_wait());
      run_access(1'b0, SIZE_WORD, 1'b0, 32'h10, 32'h0, lcg_wait());
    end
    for (int o = 0; o < 4; o += 2) begin
      run_access(1'b1, SIZE_HALF, 1'b0, 32'h14 + 32'(o), 32'h7777_c3a0 | 32'(o), lcg_wait());
      run_access(1'b0, SIZE_WORD, 1'b0, 32'h14, 32'h0, lcg_wait());
    end
  endtask

  task automatic load_extension();
    run_access(1'b1, SIZE_WORD, 1'b0, 32'h18, 32'h80f1_7f05, lcg_wait());  // mixed sign bits
    for (int s = 0; s < 2; s++) begin
      for (int o = 0; o < 4; o++)
        run_access(1'b0, SIZE_BYTE, 1'(s), 32'h18 + 32'(o), 32'h0, lcg_wait());
      for (int o = 0; o < 4; o += 2)
        run_access(1'b0, SIZE_HALF, 1'(s), 32'h18 + 32'(o), 32'h0, lcg_wait());
    end
  endtask

  task automatic withheld_grant();
    run_access(1'b0, SIZE_HALF, 1'b1, 32'h2a, 32'h0, 3);  // longest withheld grant
    run_access(1'b1, SIZE_BYTE, 1'b0, 32'h2d, 32'hffff_ff69, 2);
  endtask

  task automatic bus_errors();
    run_access(1'b0, SIZE_WORD, 1'b0, {26'd0, ERR_WORD, 2'b00}, 32'h0, lcg_wait());
    run_access(1'b1, SIZE_HALF, 1'b0, {26'd0, ERR_WORD, 2'b10}, 32'h1111_2222, lcg_wait());
    run_access(1'b0, SIZE_BYTE, 1'b1, {26'd0, ERR_WORD, 2'b11}, 32'h0, 0);
    for (int w = 0; w < 16; w++)
      run_access(1'b0, SIZE_WORD, 1'b0, 32'(w) << 2, 32'h0, lcg_wait());  // err only at one
  endtask

  initial begin
    clk_i      = 1'b0;
    rst_ni     <= 1'b0;
    req_i      <= 1'b0;
    core_req_i <= '0;
    lcg_state  = 32'd57;
    next_wait  = 0;
    n_checks   = 0;
    n_errors   = 0;
    cycles     = 0;
    for (int i = 0; i < 16; i++)
      ref_mem[i] = fill_word(i);
    repeat (3) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    reset_outputs();
    word_roundtrip();
    partial_stores();
    load_extension();
    withheld_grant();
    bus_errors();
    $display("checks %0d, errors %0d", n_checks, n_errors);
    if (n_errors == 0)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  end

endmodule

`default_nettype wire

// ==== hw/lsu_bus_pkg.sv ====
/*
 * memory bus types
 * request and response words of the grant/rvalid data bus
 */

`default_nettype none

`include "lsu_consts.svh"

package lsu_bus_pkg;

  // request towards memory, valid while data_req_o is high
  typedef struct packed {
    logic [`LSU_ADDR_W-1:0] addr;   // always word aligned
    logic                   we;
    logic [`LSU_BE_W-1:0]   be;
    logic [`LSU_DATA_W-1:0] wdata;  // already rotated into lanes
  } bus_req_t;

  typedef struct packed {
    logic [`LSU_DATA_W-1:0] rdata;
    logic                   err;    // only meaningful with rvalid
  } bus_rsp_t;

endpackage

`default_nettype wire

// ==== hw/lsu_consts.svh ====
/*
 * load/store unit widths
 * word, address, byte-enable and byte-offset sizes shared by all blocks
 */

`ifndef LSU_CONSTS_SVH
`define LSU_CONSTS_SVH

// one data word and one byte address
`define LSU_DATA_W 32
`define LSU_ADDR_W 32

// byte lanes per word
`define LSU_BE_W   4
`define LSU_OFFS_W 2  // byte offset inside a word

`endif

// ==== hw/lsu_core_pkg.sv ====
/*
 * core side types of the load/store unit
 * execute-stage request, access size and the control captured at grant
 */

`default_nettype none

`include "lsu_consts.svh"

package lsu_core_pkg;

  // access size, code 3 decodes as byte as well
  typedef enum logic [1:0] {
    SIZE_WORD = 2'd0,
    SIZE_HALF = 2'd1,
    SIZE_BYTE = 2'd2
  } lsu_size_e;

  // request from execute, held stable until req_done_o
  typedef struct packed {
    logic                   we;
    lsu_size_e              size;
    logic                   sign_ext;  // loads only
    logic [`LSU_DATA_W-1:0] wdata;     // store data, lane 0 based
    logic [`LSU_ADDR_W-1:0] addr;      // byte address
  } core_req_t;

  // what the read path needs once the bus has taken the request
  typedef struct packed {
    logic [`LSU_OFFS_W-1:0] offs;
    lsu_size_e              size;
    logic                   sign_ext;
    logic                   we;        // selects load or store error
  } xfer_ctrl_t;

endpackage

`default_nettype wire

// ==== hw/lsu_load_align.sv ====
/*
 * load alignment
 * pulls the addressed half word or byte down to bit 0 and zero- or sign-extends it
 */

`timescale 1ns/1ns
`default_nettype none

`include "lsu_consts.svh"

module lsu_load_align (
  input  lsu_core_pkg::xfer_ctrl_t  xfer_i,
  input  logic [`LSU_DATA_W-1:0]    rdata_i,
  output logic [`LSU_DATA_W-1:0]    rdata_o
);
  import lsu_core_pkg::*;

  localparam int HALF_W = `LSU_DATA_W / 2;
  localparam int BYTE_W = 8;

  logic [`LSU_DATA_W-1:0] shifted;  // addressed lane moved to bit 0
  logic [HALF_W-1:0]      half_v;
  logic [BYTE_W-1:0]      byte_v;
  logic                   half_sign;
  logic                   byte_sign;

  // offset in bytes times eight gives the bit shift
  assign shifted = rdata_i >> {xfer_i.offs, 3'b000};

  assign half_v = shifted[HALF_W-1:0];
  assign byte_v = shifted[BYTE_W-1:0];

  // fill bit is the top of the extracted value, or zero for unsigned loads
  assign half_sign = xfer_i.sign_ext & half_v[HALF_W-1];
  assign byte_sign = xfer_i.sign_ext & byte_v[BYTE_W-1];

  //////////////////////////////////////////////////////////////
  // size select
  always_comb begin
    unique case (xfer_i.size)
      SIZE_WORD: begin
        rdata_o = rdata_i;  // offset is always 0 for words
      end
      SIZE_HALF: begin
        rdata_o = {{(`LSU_DATA_W - HALF_W){half_sign}}, half_v};
      end
      default: begin
        rdata_o = {{(`LSU_DATA_W - BYTE_W){byte_sign}}, byte_v};
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== hw/lsu_req_fsm.sv ====
/*
 * request FSM
 * issues the bus request, waits for grant, qualifies the response and splits errors
 */

`timescale 1ns/1ns
`default_nettype none

module lsu_req_fsm (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic req_i,           // level from execute
  input  logic gnt_i,
  input  logic rvalid_i,
  input  logic bus_err_i,
  input  logic xfer_we_i,       // captured write flag
  output logic data_req_o,
  output logic xfer_capture_o,  // one pulse in the grant cycle
  output logic req_done_o,
  output logic resp_valid_o,
  output logic load_err_o,
  output logic store_err_o,
  output logic busy_o
);

  // one-hot state encoding
  typedef enum logic [1:0] {
    IDLE     = 2'b01,
    WAIT_GNT = 2'b10
  } state_e;

  state_e state_q;
  state_e state_d;

  //////////////////////////////////////////////////////////////
  // next state and request
  always_comb begin
    state_d        = state_q;
    data_req_o     = 1'b0;
    xfer_capture_o = 1'b0;

    unique case (state_q)
      IDLE: begin
        if (req_i) begin
          data_req_o = 1'b1;  // same cycle as req_i
          if (gnt_i) begin
            xfer_capture_o = 1'b1;  // taken at once so the FSM stays idle
          end else begin
            state_d = WAIT_GNT;
          end
        end
      end
      WAIT_GNT: begin
        data_req_o = 1'b1;  // hold until memory takes it
        if (gnt_i) begin
          xfer_capture_o = 1'b1;
          state_d        = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  //////////////////////////////////////////////////////////////
  // core side outputs
  assign req_done_o   = xfer_capture_o;                // done at grant while data comes later
  assign busy_o       = (state_q == WAIT_GNT);
  assign resp_valid_o = rvalid_i & (state_q == IDLE);
  assign load_err_o   = resp_valid_o & bus_err_i & ~xfer_we_i;
  assign store_err_o  = resp_valid_o & bus_err_i &  xfer_we_i;

  a_state_legal: assert property (@(posedge clk_i) disable iff (!rst_ni)
    state_q inside {IDLE, WAIT_GNT})
    else $error("lsu: illegal FSM state %b", state_q);

  // memory may only flag an error alongside its response
  a_err_with_rvalid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    bus_err_i |-> rvalid_i)
    else $error("lsu: bus error without rvalid");

endmodule

`default_nettype wire

// ==== hw/lsu_store_align.sv ====
/*
 * store alignment
 * byte enables from size and offset, store data rotated into the addressed lanes
 */

`timescale 1ns/1ns
`default_nettype none

`include "lsu_consts.svh"

module lsu_store_align (
  input  lsu_core_pkg::core_req_t  core_req_i,
  output logic [`LSU_BE_W-1:0]     be_o,
  output logic [`LSU_DATA_W-1:0]   wdata_o
);
  import lsu_core_pkg::*;

  logic [`LSU_OFFS_W-1:0] offs;

  assign offs = core_req_i.addr[`LSU_OFFS_W-1:0];

  //////////////////////////////////////////////////////////////
  // byte enables
  always_comb begin
    unique case (core_req_i.size)
      SIZE_WORD: be_o = '1;                               // all four lanes
      SIZE_HALF: be_o = `LSU_BE_W'(2'b11) << offs;        // two lanes from offs
      default:   be_o = `LSU_BE_W'(1'b1) << offs;         // byte, codes 2 and 3
    endcase
  end

  //////////////////////////////////////////////////////////////
  // write data, rotate left by offs bytes
  always_comb begin
    unique case (offs)
      2'd0:    wdata_o = core_req_i.wdata;
      2'd1:    wdata_o = {core_req_i.wdata[23:0], core_req_i.wdata[31:24]};
      2'd2:    wdata_o = {core_req_i.wdata[15:0], core_req_i.wdata[31:16]};
      default: wdata_o = {core_req_i.wdata[7:0], core_req_i.wdata[31:8]};
    endcase
  end

  // the core only sends naturally aligned accesses, no split transfers here
  always_comb begin
    if (!$isunknown({core_req_i.size, offs})) begin
      assert ((core_req_i.size != SIZE_WORD || offs == '0) &&
              (core_req_i.size != SIZE_HALF || !offs[0]))
        else $error("lsu: misaligned access, size %0d offset %0d", core_req_i.size, offs);
    end
  end

endmodule

`default_nettype wire

// ==== hw/lsu_top.sv ====
/*
 * load/store unit top
 * one outstanding aligned access on a grant/rvalid bus, loads aligned and extended
 */

`timescale 1ns/1ns
`default_nettype none

`include "lsu_consts.svh"

module lsu_top (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  // core side
  input  logic                    req_i,
  input  lsu_core_pkg::core_req_t core_req_i,
  output logic                    req_done_o,
  output logic                    resp_valid_o,
  output logic [`LSU_DATA_W-1:0]  rdata_o,
  output logic                    load_err_o,
  output logic                    store_err_o,
  output logic [`LSU_ADDR_W-1:0]  addr_last_o,
  output logic                    busy_o,
  // memory bus
  output logic                    data_req_o,
  output lsu_bus_pkg::bus_req_t   bus_req_o,
  input  logic                    gnt_i,
  input  logic                    rvalid_i,
  input  lsu_bus_pkg::bus_rsp_t   bus_rsp_i
);
  import lsu_core_pkg::*;

  xfer_ctrl_t             xfer;          // captured at grant
  logic                   xfer_capture;
  logic [`LSU_BE_W-1:0]   store_be;
  logic [`LSU_DATA_W-1:0] store_wdata;

  lsu_req_fsm u_req_fsm (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .req_i          (req_i),
    .gnt_i          (gnt_i),
    .rvalid_i       (rvalid_i),
    .bus_err_i      (bus_rsp_i.err),
    .xfer_we_i      (xfer.we),
    .data_req_o     (data_req_o),
    .xfer_capture_o (xfer_capture),
    .req_done_o     (req_done_o),
    .resp_valid_o   (resp_valid_o),
    .load_err_o     (load_err_o),
    .store_err_o    (store_err_o),
    .busy_o         (busy_o)
  );

  lsu_xfer_regs u_xfer_regs (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .capture_i   (xfer_capture),
    .core_req_i  (core_req_i),
    .xfer_o      (xfer),
    .addr_last_o (addr_last_o)
  );

  lsu_store_align u_store_align (
    .core_req_i (core_req_i),
    .be_o       (store_be),
    .wdata_o    (store_wdata)
  );

  lsu_load_align u_load_align (
    .xfer_i  (xfer),
    .rdata_i (bus_rsp_i.rdata),
    .rdata_o (rdata_o)
  );

  // bus request straight from the held core request, offset bits cleared
  assign bus_req_o = '{
    addr:  {core_req_i.addr[`LSU_ADDR_W-1:`LSU_OFFS_W], {`LSU_OFFS_W{1'b0}}},
    we:    core_req_i.we,
    be:    store_be,
    wdata: store_wdata
  };

endmodule

`default_nettype wire

// ==== hw/lsu_xfer_regs.sv ====
/*
 * transaction control registers
 * captures offset, size, sign and write flags plus the byte address at grant
 */

`timescale 1ns/1ns
`default_nettype none

`include "lsu_consts.svh"

module lsu_xfer_regs (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     capture_i,   // grant cycle
  input  lsu_core_pkg::core_req_t  core_req_i,
  output lsu_core_pkg::xfer_ctrl_t xfer_o,
  output logic [`LSU_ADDR_W-1:0]   addr_last_o
);
  import lsu_core_pkg::*;

  xfer_ctrl_t             xfer_q;
  logic [`LSU_ADDR_W-1:0] addr_last_q;

  // steers the read path until the next grant
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      xfer_q      <= '0;
      addr_last_q <= '0;
    end else if (capture_i) begin
      xfer_q.offs     <= core_req_i.addr[`LSU_OFFS_W-1:0];
      xfer_q.size     <= core_req_i.size;
      xfer_q.sign_ext <= core_req_i.sign_ext;
      xfer_q.we       <= core_req_i.we;
      addr_last_q     <= core_req_i.addr;  // full byte address, not word aligned
    end
  end

  assign xfer_o      = xfer_q;
  assign addr_last_o = addr_last_q;

  // the core must hold a clean request through the grant
  a_xfer_known: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !$isunknown(xfer_q))
    else $error("lsu: captured transaction control is unknown");

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# build the LSU testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module lsu_tb -f src.f -o lsu_sim

# a crash or an early stop also counts as a failure
status=0
./obj_dir/lsu_sim > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "Done: errors found" sim.log; then
  echo "simulation failed"
  exit 1
fi
echo "simulation passed"

// ==== src.f ====
+incdir+hw
hw/lsu_bus_pkg.sv
hw/lsu_core_pkg.sv
hw/lsu_store_align.sv
hw/lsu_load_align.sv
hw/lsu_xfer_regs.sv
hw/lsu_req_fsm.sv
hw/lsu_top.sv
bench/lsu_tb.sv
